/* hw/vlsu_consts.svh */
// Vector load/store address generator constants
// Bus geometry, AXI burst limits and queue sizing

`ifndef VLSU_CONSTS_SVH
`define VLSU_CONSTS_SVH

////////////////////////////////////////
// Memory bus
////////////////////////////////////////

// Byte address width
`define VLSU_ADDR_W 32

// Data bus width in bytes, and its log2
`define VLSU_BUS_BYTES 8
`define VLSU_BUS_LOG 3

////////////////////////////////////////
// AXI burst rules
////////////////////////////////////////

// Bursts never cross a 4 KiB page
`define VLSU_PAGE_BITS 12

// INCR bursts carry at most this many beats
`define VLSU_MAX_BEATS 256

////////////////////////////////////////
// Vector side
////////////////////////////////////////

// Width of the vector length field
`define VLSU_VL_W 16

// Entries in the load/store unit command queue
`define VLSU_CMD_DEPTH 2

`endif

/* hw/vlsu_pkg.sv */
// Vector instruction types
// Sequencer request format and the job handed to the burst splitter

`default_nettype none

`include "vlsu_consts.svh"

package vlsu_pkg;

  // Vector memory operations handled here
  typedef enum logic [1:0] {
    OP_VLE  = 2'd0, // unit-stride load
    OP_VSE  = 2'd1, // unit-stride store
    OP_VLSE = 2'd2, // strided load
    OP_VSSE = 2'd3  // strided store
  } vlsu_op_e;

  // Element width as log2 of bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Instruction from the sequencer
  typedef struct packed {
    vlsu_op_e                 op;
    vew_e                     vew;
    logic [`VLSU_ADDR_W-1:0]  base;
    logic [31:0]              stride;
    logic [`VLSU_VL_W-1:0]    vl;
  } vinsn_req_t;

  // Job for the splitter and its running state
  typedef struct packed {
    logic [`VLSU_ADDR_W-1:0]  addr;
    logic [`VLSU_VL_W-1:0]    vl;
    logic [31:0]              stride;
    vew_e                     vew;
    logic                     is_load;
    // Unit stride maps onto INCR bursts
    logic                     is_burst;
  } addr_job_t;

  // True for the unit-stride and strided loads
  function automatic logic op_is_load(input vlsu_op_e op);
    return (op == OP_VLE) || (op == OP_VLSE);
  endfunction

endpackage

`default_nettype wire

/* hw/axi_ax_pkg.sv */
// Memory-side types
// AXI address beat shared by AR and AW, plus load/store unit command

`default_nettype none

`include "vlsu_consts.svh"

package axi_ax_pkg;

  // AXI burst encoding
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } ax_burst_e;

  // Modifiable, non-bufferable memory
  localparam logic [3:0] CACHE_MODIFIABLE = 4'b0010;

  // AX request, same layout for AR and AW
  typedef struct packed {
    logic [`VLSU_ADDR_W-1:0] addr;
    logic [7:0]              len;
    logic [2:0]              size;
    ax_burst_e               burst;
    logic [3:0]              cache;
  } ax_beat_t;

  // Command that tells the load/store units what data to expect
  typedef struct packed {
    logic [`VLSU_ADDR_W-1:0] addr;
    logic [7:0]              len;
    logic [2:0]              size;
    logic                    is_load;
  } lsu_cmd_t;

endpackage

`default_nettype wire

/* hw/addrgen_intake.sv */
// Address generator intake
// Four-phase handshake with the sequencer, alignment check, job hand-off

`default_nettype none

module addrgen_intake import vlsu_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Sequencer side
  input  wire logic       req_i,
  input  vinsn_req_t      vinsn_i,
  output logic            ack_o,
  output logic            error_o,
  // Splitter side
  output logic            job_valid_o,
  output addr_job_t       job_o,
  input  wire logic       job_ready_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_OFFER,
    ST_ACK
  } state_e;

  state_e    state_q, state_d;
  logic      err_q, err_d;
  addr_job_t job_q;
  logic      load_job;
  logic [2:0] ew_mask;
  logic       misaligned;

  // Low address bits that must be zero for this element width
  assign ew_mask    = 3'((4'd1 << vinsn_i.vew) - 4'd1);
  assign misaligned = |(vinsn_i.base[2:0] & ew_mask);

  ////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    err_d    = err_q;
    load_job = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (req_i) begin
          if (misaligned) begin
            // Reject straight away, nothing reaches the splitter
            err_d   = 1'b1;
            state_d = ST_ACK;
          end else begin
            err_d    = 1'b0;
            load_job = 1'b1;
            state_d  = ST_OFFER;
          end
        end
      end
      ST_OFFER: begin
        if (job_ready_i) begin
          state_d = ST_ACK;
        end
      end
      ST_ACK: begin
        // Hold ack until the sequencer drops req
        if (!req_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
    end
  end

  // Job payload, captured once per accepted instruction
  always_ff @(posedge clk_i) begin
    if (load_job) begin
      job_q.addr     <= vinsn_i.base;
      job_q.vl       <= vinsn_i.vl;
      job_q.stride   <= vinsn_i.stride;
      job_q.vew      <= vinsn_i.vew;
      job_q.is_load  <= op_is_load(vinsn_i.op);
      job_q.is_burst <= (vinsn_i.op == OP_VLE) || (vinsn_i.op == OP_VSE);
    end
  end

  assign ack_o       = (state_q == ST_ACK);
  assign error_o     = ack_o && err_q;
  assign job_valid_o = (state_q == ST_OFFER);
  assign job_o       = job_q;

endmodule

`default_nettype wire

/* hw/burst_splitter.sv */
// Burst splitter
// Walks one vector memory job and emits one AX beat request per step

`default_nettype none

`include "vlsu_consts.svh"

module burst_splitter import vlsu_pkg::*; import axi_ax_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Job from the intake
  input  wire logic       job_valid_i,
  input  addr_job_t       job_i,
  output logic            job_ready_o,
  // Beats toward the issue stage
  output logic            beat_valid_o,
  output ax_beat_t        beat_o,
  output logic            beat_is_load_o,
  input  wire logic       beat_ready_i
);

  localparam int unsigned AW = `VLSU_ADDR_W;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_ISSUE
  } state_e;

  state_e          state_q, state_d;
  addr_job_t       cur_q, cur_d;
  // Last byte of the current burst
  logic [AW-1:0]   end_q, end_d;
  logic [AW-1:0]   start_aligned;
  logic [AW-1:0]   bytes_done;
  logic [AW-1:0]   elems_done;

  ////////////////////////////////////////
  // Burst end
  ////////////////////////////////////////

  // Earliest of data end, page end and the 256-beat window
  function automatic logic [AW-1:0] burst_end(input logic [AW-1:0] addr,
                                              input logic [`VLSU_VL_W-1:0] vl,
                                              input vew_e vew);
    logic [AW-1:0] data_end;
    logic [AW-1:0] page_end;
    logic [AW-1:0] win_end;
    logic [AW-1:0] result;
    // Last data byte, rounded up to the end of its bus word
    data_end = addr + (AW'(vl) << vew) - AW'(1);
    data_end = data_end | AW'(`VLSU_BUS_BYTES - 1);
    page_end = addr | AW'((1 << `VLSU_PAGE_BITS) - 1);
    win_end  = (addr & ~AW'(`VLSU_BUS_BYTES - 1)) +
               AW'(`VLSU_MAX_BEATS * `VLSU_BUS_BYTES - 1);
    result = data_end;
    if (page_end < result) begin
      result = page_end;
    end
    if (win_end < result) begin
      result = win_end;
    end
    return result;
  endfunction

  // Bus-aligned start of the current burst
  assign start_aligned = cur_q.addr & ~AW'(`VLSU_BUS_BYTES - 1);

  // Bytes covered past the current address, then in elements
  assign bytes_done = end_q - cur_q.addr + AW'(1);
  assign elems_done = bytes_done >> cur_q.vew;

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cur_d   = cur_q;
    end_d   = end_q;
    case (state_q)
      ST_IDLE: begin
        if (job_valid_i) begin
          cur_d   = job_i;
          state_d = ST_CALC;
        end
      end
      ST_CALC: begin
        // One cycle for the first burst end
        end_d   = burst_end(cur_q.addr, cur_q.vl, cur_q.vew);
        state_d = ST_ISSUE;
      end
      ST_ISSUE: begin
        if (beat_ready_i) begin
          if (cur_q.is_burst) begin
            cur_d.addr = end_q + AW'(1);
            // Saturate at zero on the last burst
            if (AW'(cur_q.vl) > elems_done) begin
              cur_d.vl = cur_q.vl - `VLSU_VL_W'(elems_done);
            end else begin
              cur_d.vl = '0;
            end
          end else begin
            cur_d.addr = cur_q.addr + cur_q.stride;
            cur_d.vl   = cur_q.vl - `VLSU_VL_W'(1);
          end
          // Next burst end ready for the following cycle
          end_d = burst_end(cur_d.addr, cur_d.vl, cur_d.vew);
          if (cur_d.vl == '0) begin
            state_d = ST_IDLE;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    cur_q <= cur_d;
    end_q <= end_d;
  end

  ////////////////////////////////////////
  // Beat request
  ////////////////////////////////////////

  always_comb begin
    beat_o.addr  = cur_q.addr;
    beat_o.burst = BURST_INCR;
    beat_o.cache = CACHE_MODIFIABLE;
    if (cur_q.is_burst) begin
      // Full bus words, len is words covered minus one
      beat_o.len  = 8'((end_q - start_aligned) >> `VLSU_BUS_LOG);
      beat_o.size = 3'(`VLSU_BUS_LOG);
    end else begin
      // Single element per request
      beat_o.len  = 8'd0;
      beat_o.size = {1'b0, cur_q.vew};
    end
  end

  assign job_ready_o    = (state_q == ST_IDLE);
  assign beat_valid_o   = (state_q == ST_ISSUE);
  assign beat_is_load_o = cur_q.is_load;

endmodule

`default_nettype wire

/* hw/ax_issue.sv */
// AX issue stage
// Drives AR or AW, queues commands for the load/store units, keeps channel order

`default_nettype none

`include "vlsu_consts.svh"

module ax_issue import axi_ax_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Beats from the splitter
  input  wire logic       beat_valid_i,
  input  ax_beat_t        beat_i,
  input  wire logic       beat_is_load_i,
  output logic            beat_ready_o,
  // AXI address channels
  output ax_beat_t        ar_o,
  output logic            ar_valid_o,
  input  wire logic       ar_ready_i,
  output ax_beat_t        aw_o,
  output logic            aw_valid_o,
  input  wire logic       aw_ready_i,
  // Load/store unit commands
  output lsu_cmd_t        cmd_o,
  output logic            cmd_valid_o,
  input  wire logic       cmd_ready_i
);

  localparam int unsigned DEPTH = `VLSU_CMD_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Output slot, one beat on either channel
  ax_beat_t   slot_q;
  logic       slot_valid_q;
  logic       slot_is_load_q;
  logic       slot_taken;
  logic       slot_free;

  // Command queue
  lsu_cmd_t   cmd_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic       q_full, q_empty;
  logic       push, pop;
  logic       dir_ok;

  assign slot_taken = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);
  assign slot_free  = !slot_valid_q || slot_taken;

  assign q_full  = (count_q == CNT_W'(DEPTH));
  assign q_empty = (count_q == '0);

  // Switching channel waits for the queue to drain
  assign dir_ok = q_empty || (cmd_mem[rd_ptr_q].is_load == beat_is_load_i);

  assign beat_ready_o = slot_free && !q_full && dir_ok;
  assign push         = beat_valid_i && beat_ready_o;
  assign pop          = cmd_valid_o && cmd_ready_i;

  ////////////////////////////////////////
  // Output slot
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q   <= 1'b0;
      slot_is_load_q <= 1'b0;
    end else if (push) begin
      slot_valid_q   <= 1'b1;
      slot_is_load_q <= beat_is_load_i;
    end else if (slot_taken) begin
      slot_valid_q   <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      slot_q <= beat_i;
    end
  end

  assign ar_o       = slot_q;
  assign aw_o       = slot_q;
  assign ar_valid_o = slot_valid_q && slot_is_load_q;
  assign aw_valid_o = slot_valid_q && !slot_is_load_q;

  ////////////////////////////////////////
  // Command queue
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      // Simultaneous push and pop keeps the count
      if (push && !pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  // Command mirrors the beat it belongs to
  always_ff @(posedge clk_i) begin
    if (push) begin
      cmd_mem[wr_ptr_q] <= '{addr: beat_i.addr, len: beat_i.len,
                             size: beat_i.size, is_load: beat_is_load_i};
    end
  end

  assign cmd_o       = cmd_mem[rd_ptr_q];
  assign cmd_valid_o = !q_empty;

endmodule

`default_nettype wire

/* hw/addrgen_top.sv */
// Vector load/store address generator
// Intake, burst splitter and AX issue stage in a chain

`default_nettype none

module addrgen_top import vlsu_pkg::*; import axi_ax_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Sequencer, four-phase
  input  wire logic       req_i,
  input  vinsn_req_t      vinsn_i,
  output logic            ack_o,
  output logic            error_o,
  // AXI AR
  output ax_beat_t        ar_o,
  output logic            ar_valid_o,
  input  wire logic       ar_ready_i,
  // AXI AW
  output ax_beat_t        aw_o,
  output logic            aw_valid_o,
  input  wire logic       aw_ready_i,
  // Load/store unit commands
  output lsu_cmd_t        cmd_o,
  output logic            cmd_valid_o,
  input  wire logic       cmd_ready_i
);

  // Intake to splitter
  addr_job_t job;
  logic      job_valid;
  logic      job_ready;

  // Splitter to issue
  ax_beat_t  beat;
  logic      beat_valid;
  logic      beat_ready;
  logic      beat_is_load;

  addrgen_intake i_intake (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .vinsn_i     (vinsn_i),
    .ack_o       (ack_o),
    .error_o     (error_o),
    .job_valid_o (job_valid),
    .job_o       (job),
    .job_ready_i (job_ready)
  );

  burst_splitter i_splitter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .job_valid_i    (job_valid),
    .job_i          (job),
    .job_ready_o    (job_ready),
    .beat_valid_o   (beat_valid),
    .beat_o         (beat),
    .beat_is_load_o (beat_is_load),
    .beat_ready_i   (beat_ready)
  );

  ax_issue i_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .beat_valid_i   (beat_valid),
    .beat_i         (beat),
    .beat_is_load_i (beat_is_load),
    .beat_ready_o   (beat_ready),
    .ar_o           (ar_o),
    .ar_valid_o     (ar_valid_o),
    .ar_ready_i     (ar_ready_i),
    .aw_o           (aw_o),
    .aw_valid_o     (aw_valid_o),
    .aw_ready_i     (aw_ready_i),
    .cmd_o          (cmd_o),
    .cmd_valid_o    (cmd_valid_o),
    .cmd_ready_i    (cmd_ready_i)
  );

endmodule

`default_nettype wire

/* sim/addrgen_properties.sv */
// Address generator handshake properties
// AX and command data held until taken, four-phase ack rule, one AX channel at a time

`default_nettype none

module addrgen_properties import axi_ax_pkg::*; (
  input wire logic     clk_i,
  input wire logic     rst_ni,
  input wire logic     req_i,
  input wire logic     ack_o,
  input wire ax_beat_t ar_o,
  input wire logic     ar_valid_o,
  input wire logic     ar_ready_i,
  input wire ax_beat_t aw_o,
  input wire logic     aw_valid_o,
  input wire logic     aw_ready_i,
  input wire lsu_cmd_t cmd_o,
  input wire logic     cmd_valid_o,
  input wire logic     cmd_ready_i
);

  // Stalled beats keep valid and data
  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("AR beat changed before it was taken");

  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
    else $error("AW beat changed before it was taken");

  cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o && !cmd_ready_i |=> cmd_valid_o && $stable(cmd_o))
    else $error("Command changed before it was taken");

  // Ack held as long as req stays high
  ack_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o && req_i |=> ack_o)
    else $error("Ack dropped while req was still high");

  ax_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ar_valid_o && aw_valid_o))
    else $error("AR and AW valid in the same cycle");

endmodule

bind addrgen_top addrgen_properties i_props (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_i       (req_i),
  .ack_o       (ack_o),
  .ar_o        (ar_o),
  .ar_valid_o  (ar_valid_o),
  .ar_ready_i  (ar_ready_i),
  .aw_o        (aw_o),
  .aw_valid_o  (aw_valid_o),
  .aw_ready_i  (aw_ready_i),
  .cmd_o       (cmd_o),
  .cmd_valid_o (cmd_valid_o),
  .cmd_ready_i (cmd_ready_i)
);

`default_nettype wire

/* sim/addrgen_tb.sv */
// Address generator testbench
// Table of vector instructions over four-phase req/ack, reference model
// for AR/AW beats and load/store commands, random back-pressure, watchdog

`default_nettype none

`include "vlsu_consts.svh"

module addrgen_tb import vlsu_pkg::*; import axi_ax_pkg::*; ();

  localparam int N_TESTS         = 8;
  localparam int RST_CYCLES      = 16;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int DRAIN_CYCLES    = 500;
  localparam int SEED            = 83466;

  // One table row, instruction plus expected rejection
  typedef struct packed {
    vinsn_req_t insn;
    logic       exp_err;
  } test_t;

  logic       clk_i;
  logic       rst_ni;
  logic       req_i;
  vinsn_req_t vinsn_i;
  logic       ack_o;
  logic       error_o;
  ax_beat_t   ar_o;
  logic       ar_valid_o;
  logic       ar_ready_i;
  ax_beat_t   aw_o;
  logic       aw_valid_o;
  logic       aw_ready_i;
  lsu_cmd_t   cmd_o;
  logic       cmd_valid_o;
  logic       cmd_ready_i;

  test_t      tbl [N_TESTS];
  // Expected traffic, in issue order
  ax_beat_t   exp_ar [$];
  ax_beat_t   exp_aw [$];
  lsu_cmd_t   exp_cmd [$];

  addrgen_top i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .vinsn_i     (vinsn_i),
    .ack_o       (ack_o),
    .error_o     (error_o),
    .ar_o        (ar_o),
    .ar_valid_o  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .aw_o        (aw_o),
    .aw_valid_o  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .cmd_o       (cmd_o),
    .cmd_valid_o (cmd_valid_o),
    .cmd_ready_i (cmd_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Error handling
  ////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic wrong_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    stop_run($sformatf("Fail at %0t: %s got 0x%0h expected 0x%0h",
                       $time, name, got, exp));
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  function automatic test_t make_test(input vlsu_op_e op, input vew_e vew,
                                      input logic [31:0] base, input logic [31:0] stride,
                                      input logic [15:0] vl, input logic err);
    test_t t;
    t.insn.op     = op;
    t.insn.vew    = vew;
    t.insn.base   = base;
    t.insn.stride = stride;
    t.insn.vl     = vl;
    t.exp_err     = err;
    return t;
  endfunction

  task automatic build_table();
    // Load inside one page, 10 bus words
    tbl[0] = make_test(OP_VLE,  EW32, 32'h1000_0100, 32'h0,   16'd20,   1'b0);
    // Store across a 4 KiB boundary
    tbl[1] = make_test(OP_VSE,  EW64, 32'h2000_0FC0, 32'h0,   16'd16,   1'b0);
    // Long load, cut at 256 beats
    tbl[2] = make_test(OP_VLE,  EW8,  32'h3000_0000, 32'h0,   16'd3000, 1'b0);
    tbl[3] = make_test(OP_VSSE, EW16, 32'h4000_0002, 32'h40,  16'd5,    1'b0);
    // Misaligned bases, rejected
    tbl[4] = make_test(OP_VLE,  EW32, 32'h5000_0002, 32'h0,   16'd8,    1'b1);
    tbl[5] = make_test(OP_VSSE, EW64, 32'h7000_0004, 32'h8,   16'd4,    1'b1);
    // Load then store, channel switch
    tbl[6] = make_test(OP_VLSE, EW32, 32'h6000_0010, 32'h100, 16'd3,    1'b0);
    tbl[7] = make_test(OP_VSE,  EW8,  32'h6000_0003, 32'h0,   16'd37,   1'b0);
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  task automatic predict_beats(input vinsn_req_t v);
    logic [31:0] addr;
    logic [31:0] start;
    logic [31:0] last;
    logic [31:0] page_last;
    logic [31:0] win_last;
    logic [31:0] covered;
    int unsigned remaining;
    logic        is_load;
    logic        unit;
    ax_beat_t    b;
    lsu_cmd_t    c;
    is_load   = (v.op == OP_VLE) || (v.op == OP_VLSE);
    unit      = (v.op == OP_VLE) || (v.op == OP_VSE);
    addr      = v.base;
    remaining = v.vl;
    while (remaining > 0) begin
      b.addr  = addr;
      b.burst = BURST_INCR;
      b.cache = CACHE_MODIFIABLE;
      if (unit) begin
        start     = addr & ~32'(`VLSU_BUS_BYTES - 1);
        // Last data byte, to the end of its bus word
        last      = (addr + 32'(remaining << v.vew) - 32'd1) | 32'(`VLSU_BUS_BYTES - 1);
        page_last = addr | 32'((1 << `VLSU_PAGE_BITS) - 1);
        win_last  = start + 32'(`VLSU_MAX_BEATS * `VLSU_BUS_BYTES) - 32'd1;
        if (page_last < last) last = page_last;
        if (win_last < last) last = win_last;
        b.len     = 8'((last - start) >> `VLSU_BUS_LOG);
        b.size    = 3'(`VLSU_BUS_LOG);
        covered   = (last - addr + 32'd1) >> v.vew;
        remaining = (remaining > covered) ? remaining - covered : 0;
        addr      = last + 32'd1;
      end else begin
        b.len     = 8'd0;
        b.size    = {1'b0, v.vew};
        remaining = remaining - 1;
        addr      = addr + v.stride;
      end
      c.addr    = b.addr;
      c.len     = b.len;
      c.size    = b.size;
      c.is_load = is_load;
      if (is_load) exp_ar.push_back(b);
      else exp_aw.push_back(b);
      exp_cmd.push_back(c);
    end
  endtask

  ////////////////////////////////////////
  // Sequencer side
  ////////////////////////////////////////

  // Full four-phase cycle, error flag checked while ack is high
  task automatic apply_insn(input test_t t);
    @(posedge clk_i);
    vinsn_i <= t.insn;
    req_i   <= 1'b1;
    @(negedge clk_i);
    while (!ack_o) @(negedge clk_i);
    assert (error_o == t.exp_err)
      else wrong_value("error_o", 64'(error_o), 64'(t.exp_err));
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    while (ack_o) @(negedge clk_i);
  endtask

  // Random back-pressure on AR, AW and commands
  initial begin
    ar_ready_i  = 1'b0;
    aw_ready_i  = 1'b0;
    cmd_ready_i = 1'b0;
    void'($urandom(SEED));
    forever begin
      @(posedge clk_i);
      ar_ready_i  <= ($urandom % 4) != 0;
      aw_ready_i  <= ($urandom % 4) != 0;
      cmd_ready_i <= ($urandom % 3) != 0;
    end
  end

  ////////////////////////////////////////
  // Output checks
  ////////////////////////////////////////

  // Sampled mid-cycle, where valid, ready and data are settled
  always @(negedge clk_i) begin
    ax_beat_t exp_b;
    lsu_cmd_t exp_c;
    if (rst_ni) begin
      if (ar_valid_o && ar_ready_i) begin
        assert (exp_ar.size() != 0) else stop_run("AR beat issued when none was expected");
        exp_b = exp_ar.pop_front();
        assert (ar_o == exp_b) else wrong_value("ar_o", 64'(ar_o), 64'(exp_b));
      end
      if (aw_valid_o && aw_ready_i) begin
        assert (exp_aw.size() != 0) else stop_run("AW beat issued when none was expected");
        exp_b = exp_aw.pop_front();
        assert (aw_o == exp_b) else wrong_value("aw_o", 64'(aw_o), 64'(exp_b));
      end
      if (cmd_valid_o && cmd_ready_i) begin
        assert (exp_cmd.size() != 0) else stop_run("Command issued when none was expected");
        exp_c = exp_cmd.pop_front();
        assert (cmd_o == exp_c) else wrong_value("cmd_o", 64'(cmd_o), 64'(exp_c));
      end
      // Other channel only once the queue has drained
      assert (!(aw_valid_o && cmd_valid_o && cmd_o.is_load))
        else stop_run("AW beat valid while a load command is still queued");
      assert (!(ar_valid_o && cmd_valid_o && !cmd_o.is_load))
        else stop_run("AR beat valid while a store command is still queued");
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int n;
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    vinsn_i = '0;
    build_table();
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (!ack_o && !error_o && !ar_valid_o && !aw_valid_o && !cmd_valid_o)
      else stop_run("Outputs not idle after reset");
    for (int i = 0; i < N_TESTS; i++) begin
      if (!tbl[i].exp_err) predict_beats(tbl[i].insn);
      apply_insn(tbl[i]);
    end
    // Let the last beats and commands drain
    n = 0;
    while ((exp_ar.size() + exp_aw.size() + exp_cmd.size()) != 0 && n < DRAIN_CYCLES) begin
      @(negedge clk_i);
      n++;
    end
    repeat (10) @(negedge clk_i);
    if (exp_ar.size() == 0 && exp_aw.size() == 0 && exp_cmd.size() == 0 &&
        !ar_valid_o && !aw_valid_o && !cmd_valid_o) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      stop_run("Run ended with AX beats or commands still outstanding");
    end
  end

  // Watchdog, sized by the table length
  initial begin
    repeat (RST_CYCLES + N_TESTS * CYCLES_PER_TEST) @(posedge clk_i);
    stop_run("Timeout: the DUT did not finish the instruction table in time");
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+hw
hw/vlsu_pkg.sv
hw/axi_ax_pkg.sv
hw/addrgen_intake.sv
hw/burst_splitter.sv
hw/ax_issue.sv
hw/addrgen_top.sv
sim/addrgen_properties.sv
sim/addrgen_tb.sv

/* Makefile */
# Verilator build for the vector load/store address generator

VERILATOR ?= verilator
TOP       ?= addrgen_tb
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST)) hw/vlsu_consts.svh
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o V$(TOP)

# Exit status of the simulation is the test result
run: $(EXE)
	./$(EXE)

clean:
	rm -rf $(BUILD_DIR)
